//--- logic/rob_pkg.sv
// ROB package: sizes, index widths, pointer, entry and FSM state types
package rob_pkg;

    // ========================================
    // Lane counts
    // ========================================
    // Dispatch lanes per cycle
    localparam int DP_WIDTH    = 2;
    // Completion bus lanes
    localparam int CDB_WIDTH   = 2;
    // Retire lanes per cycle
    localparam int RT_WIDTH    = 2;

    // ========================================
    // Storage sizes
    // ========================================
    localparam int ROB_ENTRIES = 16;
    localparam int ROB_IDX_W   = $clog2(ROB_ENTRIES);
    // 32 architectural registers
    localparam int ARCH_REG_W  = 5;
    // 64 physical registers
    localparam int TAG_W       = 6;
    // Per-cycle dispatch or retire count, 0 to 2
    localparam int CNT_W       = $clog2(DP_WIDTH + 1);

    // Index plus wrap bit in the MSB
    typedef logic [ROB_IDX_W:0] rob_ptr_t;
    typedef logic [CNT_W-1:0]   rob_cnt_t;

    // One stored entry, 21 bits
    typedef struct packed {
        logic                  valid;
        logic                  complete;
        logic                  mispredict;
        logic                  is_branch;
        logic [ARCH_REG_W-1:0] arch_reg;
        logic [TAG_W-1:0]      tag;
        logic [TAG_W-1:0]      tag_old;
    } rob_entry_t;

    // Recovery FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_FLUSH
    } rob_state_e;

endpackage

//--- logic/rob_ptr_if.sv
// ROB pointer bus: head/tail from the counter, lane counts and flush back to it
interface rob_ptr_if;
    import rob_pkg::*;

    // Wrap-bit pointers, owned by the counter
    rob_ptr_t head;
    rob_ptr_t tail;
    // Accepted dispatches this cycle
    rob_cnt_t dp_count;
    // Retiring entries this cycle
    rob_cnt_t rt_count;
    // One-cycle precise-state flush
    logic     flush;

    // Pointer counter side
    modport ctrl (
        output head,
        output tail,
        input  dp_count,
        input  rt_count,
        input  flush
    );

    // Entry array side
    modport array (
        input  head,
        input  tail,
        input  flush,
        output dp_count,
        output rt_count
    );

    // Recovery FSM only drives flush
    modport fsm (output flush);

endinterface

//--- logic/rob_ptr_ctrl.sv
// ROB pointer counter holding head and tail with wrap bits, free count and dispatch readiness
module rob_ptr_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_i,
    rob_ptr_if.ctrl                      ptr,
    input  logic                         stall_i,
    output logic [rob_pkg::DP_WIDTH-1:0] rob_ready_o
);
    import rob_pkg::*;

    // ========================================
    // Pointer state
    // ========================================
    rob_ptr_t             head_q;
    rob_ptr_t             tail_q;

    // Occupancy decode
    logic [ROB_IDX_W:0]   used_cnt;
    logic [ROB_IDX_W:0]   free_cnt;

    assign ptr.head = head_q;
    assign ptr.tail = tail_q;

    // ========================================
    // Occupancy and ready
    // ========================================
    // Wrap bit makes the distance 0 when empty and 16 when full
    assign used_cnt = tail_q - head_q;
    assign free_cnt = (ROB_IDX_W+1)'(ROB_ENTRIES) - used_cnt;

    // Thermometer where bit i means more than i free slots
    always_comb begin
        for (int i = 0; i < DP_WIDTH; i++) begin
            rob_ready_o[i] = !stall_i && (free_cnt > (ROB_IDX_W+1)'(i));
        end
    end

    // ========================================
    // Pointer update
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i || ptr.flush) begin
            // Back to the empty precise state
            head_q <= '0;
            tail_q <= '0;
        end else begin
            // Retire moves head and dispatch moves tail
            head_q <= head_q + rob_ptr_t'(ptr.rt_count);
            tail_q <= tail_q + rob_ptr_t'(ptr.dp_count);
        end
    end

endmodule

//--- logic/rob_entry_array.sv
// ROB entry array: dispatch writes, CDB/branch marking and in-order retire select
module rob_entry_array (
    input  logic                                                      clk_i,
    input  logic                                                      rst_i,
    rob_ptr_if.array                                                  ptr,
    // Dispatch lanes
    input  logic [rob_pkg::DP_WIDTH-1:0]                              dp_en_i,
    input  logic [rob_pkg::DP_WIDTH-1:0][rob_pkg::ARCH_REG_W-1:0]     dp_arch_reg_i,
    input  logic [rob_pkg::DP_WIDTH-1:0][rob_pkg::TAG_W-1:0]          dp_tag_i,
    input  logic [rob_pkg::DP_WIDTH-1:0][rob_pkg::TAG_W-1:0]          dp_tag_old_i,
    input  logic [rob_pkg::DP_WIDTH-1:0]                              dp_is_br_i,
    // Completion bus
    input  logic [rob_pkg::CDB_WIDTH-1:0]                             cdb_valid_i,
    input  logic [rob_pkg::CDB_WIDTH-1:0][rob_pkg::ROB_IDX_W-1:0]     cdb_rob_idx_i,
    // Branch resolver
    input  logic                                                      br_valid_i,
    input  logic                                                      br_mispredict_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0]                             br_rob_idx_i,
    // Retire lanes
    output logic [rob_pkg::RT_WIDTH-1:0]                              rt_valid_o,
    output logic [rob_pkg::RT_WIDTH-1:0][rob_pkg::ARCH_REG_W-1:0]     rt_arch_reg_o,
    output logic [rob_pkg::RT_WIDTH-1:0][rob_pkg::TAG_W-1:0]          rt_tag_o,
    output logic [rob_pkg::RT_WIDTH-1:0][rob_pkg::TAG_W-1:0]          rt_tag_old_o,
    output logic                                                      rt_mispredict_o
);
    import rob_pkg::*;

    // ========================================
    // Storage and lane indices
    // ========================================
    rob_entry_t                            rob_q [ROB_ENTRIES];

    logic [ROB_IDX_W-1:0]                  head_idx;
    logic [ROB_IDX_W-1:0]                  tail_idx;
    logic [DP_WIDTH-1:0][ROB_IDX_W-1:0]    dp_idx;
    logic [RT_WIDTH-1:0][ROB_IDX_W-1:0]    rt_idx;
    rob_cnt_t                              dp_count_w;
    rob_cnt_t                              rt_count_w;
    // Still retiring in order, cleared at a gap or a mispredict
    logic                                  retire_run;

    assign head_idx = ptr.head[ROB_IDX_W-1:0];
    assign tail_idx = ptr.tail[ROB_IDX_W-1:0];

    // Dispatch slots at tail, tail+1, wrapping mod 16
    always_comb begin
        dp_count_w = '0;
        for (int i = 0; i < DP_WIDTH; i++) begin
            dp_idx[i]  = tail_idx + ROB_IDX_W'(i);
            dp_count_w = dp_count_w + rob_cnt_t'(dp_en_i[i]);
        end
    end

    // ========================================
    // Retire selection
    // ========================================
    always_comb begin
        // Nothing retires in the flush cycle
        retire_run      = !ptr.flush;
        rt_mispredict_o = 1'b0;
        rt_count_w      = '0;
        for (int i = 0; i < RT_WIDTH; i++) begin
            rt_idx[i]        = head_idx + ROB_IDX_W'(i);
            rt_valid_o[i]    = retire_run && rob_q[rt_idx[i]].valid &&
                               rob_q[rt_idx[i]].complete;
            rt_arch_reg_o[i] = rob_q[rt_idx[i]].arch_reg;
            rt_tag_o[i]      = rob_q[rt_idx[i]].tag;
            rt_tag_old_o[i]  = rob_q[rt_idx[i]].tag_old;
            rt_mispredict_o  = rt_mispredict_o ||
                               (rt_valid_o[i] && rob_q[rt_idx[i]].mispredict);
            rt_count_w       = rt_count_w + rob_cnt_t'(rt_valid_o[i]);
            // Younger lanes stop after a mispredicted branch
            retire_run       = rt_valid_o[i] && !rob_q[rt_idx[i]].mispredict;
        end
    end

    assign ptr.dp_count = dp_count_w;
    assign ptr.rt_count = rt_count_w;

    // ========================================
    // Entry update
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i || ptr.flush) begin
            // Flags only, payload left stale
            for (int e = 0; e < ROB_ENTRIES; e++) begin
                rob_q[e].valid      <= 1'b0;
                rob_q[e].complete   <= 1'b0;
                rob_q[e].mispredict <= 1'b0;
            end
        end else begin
            // CDB completion
            for (int c = 0; c < CDB_WIDTH; c++) begin
                if (cdb_valid_i[c]) begin
                    rob_q[cdb_rob_idx_i[c]].complete <= 1'b1;
                end
            end
            // Mispredict flag, branch entries only
            if (br_valid_i && br_mispredict_i && rob_q[br_rob_idx_i].is_branch) begin
                rob_q[br_rob_idx_i].mispredict <= 1'b1;
            end
            // Free retired slots, after marking so no stale complete survives
            for (int r = 0; r < RT_WIDTH; r++) begin
                if (rt_valid_o[r]) begin
                    rob_q[rt_idx[r]].valid      <= 1'b0;
                    rob_q[rt_idx[r]].complete   <= 1'b0;
                    rob_q[rt_idx[r]].mispredict <= 1'b0;
                end
            end
            // New entries at tail
            for (int d = 0; d < DP_WIDTH; d++) begin
                if (dp_en_i[d]) begin
                    rob_q[dp_idx[d]] <= '{valid:      1'b1,
                                          complete:   1'b0,
                                          mispredict: 1'b0,
                                          is_branch:  dp_is_br_i[d],
                                          arch_reg:   dp_arch_reg_i[d],
                                          tag:        dp_tag_i[d],
                                          tag_old:    dp_tag_old_i[d]};
                end
            end
        end
    end

endmodule

//--- logic/rob_recover_fsm.sv
// ROB recovery FSM: stalls dispatch after a mispredict, then flushes for one cycle
module rob_recover_fsm (
    input  logic    clk_i,
    input  logic    rst_i,
    rob_ptr_if.fsm  ptr,
    input  logic    br_valid_i,
    input  logic    br_mispredict_i,
    input  logic    rt_mispredict_i,
    output logic    stall_o,
    output logic    flush_o
);
    import rob_pkg::*;

    // ========================================
    // State register
    // ========================================
    rob_state_e state_q;
    rob_state_e state_d;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Resolver reports a wrong-path branch
                if (br_valid_i && br_mispredict_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // Hold until the bad branch leaves the head
                if (rt_mispredict_i) begin
                    state_d = ST_FLUSH;
                end
            end
            ST_FLUSH: begin
                // Single cycle, pointers and valids clear at its end
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ========================================
    // Outputs
    // ========================================
    // No dispatch while waiting or flushing
    assign stall_o  = (state_q != ST_IDLE);
    assign flush_o  = (state_q == ST_FLUSH);
    assign ptr.flush = flush_o;

endmodule

//--- logic/rob_top.sv
// ROB top level: two-wide dispatch, CDB completion, in-order retire and flush
module rob_top (
    input  logic                                                   clk_i,
    input  logic                                                   rst_i,
    // Dispatch handshake
    output logic [rob_pkg::DP_WIDTH-1:0]                           rob_ready_o,
    input  logic [rob_pkg::DP_WIDTH-1:0]                           dp_en_i,
    input  logic [rob_pkg::DP_WIDTH-1:0][rob_pkg::ARCH_REG_W-1:0]  dp_arch_reg_i,
    input  logic [rob_pkg::DP_WIDTH-1:0][rob_pkg::TAG_W-1:0]       dp_tag_i,
    input  logic [rob_pkg::DP_WIDTH-1:0][rob_pkg::TAG_W-1:0]       dp_tag_old_i,
    input  logic [rob_pkg::DP_WIDTH-1:0]                           dp_is_br_i,
    // Lane 0 index, lane 1 is the next slot
    output logic [rob_pkg::ROB_IDX_W-1:0]                          dp_rob_idx_o,
    // Completion bus
    input  logic [rob_pkg::CDB_WIDTH-1:0]                          cdb_valid_i,
    input  logic [rob_pkg::CDB_WIDTH-1:0][rob_pkg::ROB_IDX_W-1:0]  cdb_rob_idx_i,
    // Branch resolver
    input  logic                                                   br_valid_i,
    input  logic                                                   br_mispredict_i,
    input  logic [rob_pkg::ROB_IDX_W-1:0]                          br_rob_idx_i,
    // Retire to map table and free list
    output logic [rob_pkg::RT_WIDTH-1:0]                           rt_valid_o,
    output logic [rob_pkg::RT_WIDTH-1:0][rob_pkg::ARCH_REG_W-1:0]  rt_arch_reg_o,
    output logic [rob_pkg::RT_WIDTH-1:0][rob_pkg::TAG_W-1:0]       rt_tag_o,
    output logic [rob_pkg::RT_WIDTH-1:0][rob_pkg::TAG_W-1:0]       rt_tag_old_o,
    // Precise-state flush
    output logic                                                   flush_o
);
    import rob_pkg::*;

    // ========================================
    // Internal links
    // ========================================
    rob_ptr_if ptr_if ();

    logic stall;
    logic rt_mispredict;

    // Slot for lane 0 is the tail index
    assign dp_rob_idx_o = ptr_if.tail[ROB_IDX_W-1:0];

    // ========================================
    // Blocks
    // ========================================
    rob_ptr_ctrl u_ptr_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ptr         (ptr_if.ctrl),
        .stall_i     (stall),
        .rob_ready_o (rob_ready_o)
    );

    rob_entry_array u_entry_array (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .ptr             (ptr_if.array),
        .dp_en_i         (dp_en_i),
        .dp_arch_reg_i   (dp_arch_reg_i),
        .dp_tag_i        (dp_tag_i),
        .dp_tag_old_i    (dp_tag_old_i),
        .dp_is_br_i      (dp_is_br_i),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_rob_idx_i   (cdb_rob_idx_i),
        .br_valid_i      (br_valid_i),
        .br_mispredict_i (br_mispredict_i),
        .br_rob_idx_i    (br_rob_idx_i),
        .rt_valid_o      (rt_valid_o),
        .rt_arch_reg_o   (rt_arch_reg_o),
        .rt_tag_o        (rt_tag_o),
        .rt_tag_old_o    (rt_tag_old_o),
        .rt_mispredict_o (rt_mispredict)
    );

    // Dispatch stall and flush timing
    rob_recover_fsm u_recover_fsm (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .ptr             (ptr_if.fsm),
        .br_valid_i      (br_valid_i),
        .br_mispredict_i (br_mispredict_i),
        .rt_mispredict_i (rt_mispredict),
        .stall_o         (stall),
        .flush_o         (flush_o)
    );

endmodule

//--- dv/rob_tb.sv
// ROB testbench with a queue reference model, assertion checks and directed and random stimulus
module rob_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rob_pkg::*;

    // Reference entry for each dispatched instruction
    typedef struct packed {
        logic [ROB_IDX_W-1:0]  idx;
        logic [ARCH_REG_W-1:0] arch_reg;
        logic [TAG_W-1:0]      tag;
        logic [TAG_W-1:0]      tag_old;
        logic                  done;
        logic                  mp;
    } model_entry_t;

    logic                                clk_i;
    logic                                rst_i;
    logic [DP_WIDTH-1:0]                 rob_ready_o;
    logic [DP_WIDTH-1:0]                 dp_en_i;
    logic [DP_WIDTH-1:0][ARCH_REG_W-1:0] dp_arch_reg_i;
    logic [DP_WIDTH-1:0][TAG_W-1:0]      dp_tag_i;
    logic [DP_WIDTH-1:0][TAG_W-1:0]      dp_tag_old_i;
    logic [DP_WIDTH-1:0]                 dp_is_br_i;
    logic [ROB_IDX_W-1:0]                dp_rob_idx_o;
    logic [CDB_WIDTH-1:0]                cdb_valid_i;
    logic [CDB_WIDTH-1:0][ROB_IDX_W-1:0] cdb_rob_idx_i;
    logic                                br_valid_i;
    logic                                br_mispredict_i;
    logic [ROB_IDX_W-1:0]                br_rob_idx_i;
    logic [RT_WIDTH-1:0]                 rt_valid_o;
    logic [RT_WIDTH-1:0][ARCH_REG_W-1:0] rt_arch_reg_o;
    logic [RT_WIDTH-1:0][TAG_W-1:0]      rt_tag_o;
    logic [RT_WIDTH-1:0][TAG_W-1:0]      rt_tag_old_o;
    logic                                flush_o;

    // Model state updated at each rising edge
    model_entry_t         model_q[$];
    logic [ROB_IDX_W-1:0] exp_tail;
    logic                 model_stall;
    logic                 exp_flush;
    int                   err_count;
    int                   err_mark;
    int                   test_count;

    rob_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ========================================
    // Reporting and model helpers
    // ========================================
    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        err_count++;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s: %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    // Sets done or mispredict on the model entry holding idx
    task automatic mark_entry(input logic [ROB_IDX_W-1:0] idx, input bit as_mp);
        model_entry_t ent;
        for (int k = 0; k < model_q.size(); k++) begin
            if (model_q[k].idx == idx) begin
                ent = model_q[k];
                if (as_mp) begin
                    ent.mp = 1'b1;
                end else begin
                    ent.done = 1'b1;
                end
                model_q[k] = ent;
            end
        end
    endtask

    // ========================================
    // Checker sampling pre-edge values
    // ========================================
    always @(posedge clk_i) begin
        logic [1:0]   exp_rt;
        logic [1:0]   exp_ready;
        logic         next_flush;
        int           free_n;
        model_entry_t new_ent;
        if (rst_i) begin
            model_q.delete();
            exp_tail    = '0;
            model_stall = 1'b0;
            exp_flush   = 1'b0;
        end else begin
            // Ready thermometer from model occupancy and zero while stalled
            free_n    = ROB_ENTRIES - model_q.size();
            exp_ready = model_stall ? 2'b00 : {free_n >= 2, free_n >= 1};
            assert (rob_ready_o == exp_ready)
                else value_error("rob_ready_o", 32'(rob_ready_o), 32'(exp_ready));
            assert (flush_o == exp_flush)
                else value_error("flush_o", 32'(flush_o), 32'(exp_flush));
            // Oldest two done entries with lane 1 cut after a bad branch
            exp_rt[0] = !exp_flush && model_q.size() > 0 && model_q[0].done;
            exp_rt[1] = exp_rt[0] && !model_q[0].mp && model_q.size() > 1 && model_q[1].done;
            assert (rt_valid_o == exp_rt)
                else value_error("rt_valid_o", 32'(rt_valid_o), 32'(exp_rt));
            for (int i = 0; i < RT_WIDTH; i++) begin
                if (rt_valid_o[i] && exp_rt[i]) begin
                    assert (rt_arch_reg_o[i] == model_q[i].arch_reg)
                        else value_error($sformatf("rt_arch_reg_o[%0d]", i),
                                         32'(rt_arch_reg_o[i]), 32'(model_q[i].arch_reg));
                    assert (rt_tag_o[i] == model_q[i].tag)
                        else value_error($sformatf("rt_tag_o[%0d]", i),
                                         32'(rt_tag_o[i]), 32'(model_q[i].tag));
                    assert (rt_tag_old_o[i] == model_q[i].tag_old)
                        else value_error($sformatf("rt_tag_old_o[%0d]", i),
                                         32'(rt_tag_old_o[i]), 32'(model_q[i].tag_old));
                end
            end
            // The retiring bad branch may sit in either lane
            next_flush = (exp_rt[0] && model_q[0].mp) || (exp_rt[1] && model_q[1].mp);
            for (int i = 0; i < RT_WIDTH; i++) begin
                if (exp_rt[i]) begin
                    void'(model_q.pop_front());
                end
            end
            for (int c = 0; c < CDB_WIDTH; c++) begin
                if (cdb_valid_i[c]) begin
                    mark_entry(cdb_rob_idx_i[c], 1'b0);
                end
            end
            if (br_valid_i && br_mispredict_i) begin
                model_stall = 1'b1;
                mark_entry(br_rob_idx_i, 1'b1);
            end
            if (dp_en_i[0]) begin
                assert (dp_rob_idx_o == exp_tail)
                    else value_error("dp_rob_idx_o", 32'(dp_rob_idx_o), 32'(exp_tail));
            end
            for (int d = 0; d < DP_WIDTH; d++) begin
                if (dp_en_i[d]) begin
                    new_ent = '{idx: exp_tail, arch_reg: dp_arch_reg_i[d],
                                tag: dp_tag_i[d], tag_old: dp_tag_old_i[d],
                                done: 1'b0, mp: 1'b0};
                    model_q.push_back(new_ent);
                    exp_tail = exp_tail + ROB_IDX_W'(1);
                end
            end
            // Flush cycle ends in the empty state
            if (exp_flush) begin
                model_q.delete();
                exp_tail    = '0;
                model_stall = 1'b0;
            end
            exp_flush = next_flush;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i) rt_valid_o != 2'b10)
        else begin
            err_count++;
            $display("Retire lane 1 was valid without lane 0");
        end
    assert property (@(posedge clk_i) disable iff (rst_i) flush_o |=> !flush_o)
        else begin
            err_count++;
            $display("Flush stayed high for more than one cycle");
        end

    // ========================================
    // Stimulus helpers driving on the falling edge
    // ========================================
    task automatic clear_inputs();
        dp_en_i         = '0;
        dp_arch_reg_i   = '0;
        dp_tag_i        = '0;
        dp_tag_old_i    = '0;
        dp_is_br_i      = '0;
        cdb_valid_i     = '0;
        cdb_rob_idx_i   = '0;
        br_valid_i      = 1'b0;
        br_mispredict_i = 1'b0;
        br_rob_idx_i    = '0;
    endtask

    task automatic cycle();
        @(negedge clk_i);
        clear_inputs();
    endtask

    task automatic set_dispatch(input int lane, input bit is_br);
        dp_en_i[lane]       = 1'b1;
        dp_is_br_i[lane]    = is_br;
        dp_arch_reg_i[lane] = ARCH_REG_W'($urandom);
        dp_tag_i[lane]      = TAG_W'($urandom);
        dp_tag_old_i[lane]  = TAG_W'($urandom);
    endtask

    // Completes up to two distinct unfinished entries in any order
    task automatic complete_random();
        logic [ROB_IDX_W-1:0] open_q[$];
        int                   pick;
        for (int k = 0; k < model_q.size(); k++) begin
            if (!model_q[k].done) begin
                open_q.push_back(model_q[k].idx);
            end
        end
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (open_q.size() > 0 && $urandom_range(3, 0) != 0) begin
                pick             = int'($urandom_range(open_q.size() - 1, 0));
                cdb_valid_i[c]   = 1'b1;
                cdb_rob_idx_i[c] = open_q[pick];
                open_q.delete(pick);
            end
        end
    endtask

    // Waits for flush or a model size while optionally feeding completions
    task automatic wait_for(input bit on_flush, input int target, input bit feed,
                            input string what);
        bit reached;
        reached = 1'b0;
        for (int t = 0; t < 100 && !reached; t++) begin
            cycle();
            reached = on_flush ? flush_o : (model_q.size() == target);
            if (!reached && feed) begin
                complete_random();
            end
        end
        if (!reached) begin
            err_count++;
            $display("Timed out waiting for %s", what);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        err_count  = 0;
        err_mark   = 0;
        test_count = 0;
        rst_i      = 1'b1;
        clear_inputs();
        void'($urandom(32'hb598_7139));
        repeat (8) @(posedge clk_i);
        cycle();
        rst_i = 1'b0;

        cycle();
        assert (rob_ready_o == 2'b11)
            else value_error("rob_ready_o", 32'(rob_ready_o), 32'h3);
        assert (rt_valid_o == '0)
            else value_error("rt_valid_o", 32'(rt_valid_o), 32'h0);
        assert (flush_o == 1'b0)
            else value_error("flush_o", 32'(flush_o), 32'h0);
        end_test("reset_ready");

        // Fill all sixteen slots two per cycle
        for (int k = 0; k < 8; k++) begin
            cycle();
            set_dispatch(0, 1'b0);
            set_dispatch(1, 1'b0);
        end
        cycle();
        assert (rob_ready_o == 2'b00)
            else value_error("rob_ready_o", 32'(rob_ready_o), 32'h0);
        cdb_valid_i[0]   = 1'b1;
        cdb_rob_idx_i[0] = model_q[0].idx;
        wait_for(1'b0, 15, 1'b0, "first retire from a full ROB");
        assert (rob_ready_o == 2'b01)
            else value_error("rob_ready_o", 32'(rob_ready_o), 32'h1);
        wait_for(1'b0, 0, 1'b1, "drain after full");
        end_test("index_full");

        // Random dispatch with out-of-order completion
        for (int k = 0; k < 80; k++) begin
            cycle();
            if ($urandom_range(2, 0) >= 1 && rob_ready_o[0]) begin
                set_dispatch(0, 1'b0);
                if ($urandom_range(1, 0) == 1 && rob_ready_o[1]) begin
                    set_dispatch(1, 1'b0);
                end
            end
            complete_random();
        end
        wait_for(1'b0, 0, 1'b1, "drain after random traffic");
        end_test("in_order_retire");

        // Both oldest entries complete together
        cycle();
        set_dispatch(0, 1'b0);
        set_dispatch(1, 1'b0);
        cycle();
        cdb_valid_i      = 2'b11;
        cdb_rob_idx_i[0] = model_q[0].idx;
        cdb_rob_idx_i[1] = model_q[1].idx;
        cycle();
        assert (rt_valid_o == 2'b11)
            else value_error("rt_valid_o", 32'(rt_valid_o), 32'h3);
        wait_for(1'b0, 0, 1'b0, "dual retire drain");
        end_test("dual_retire");

        // Branch at head with younger entries finishing first
        cycle();
        set_dispatch(0, 1'b1);
        set_dispatch(1, 1'b0);
        cycle();
        set_dispatch(0, 1'b0);
        set_dispatch(1, 1'b0);
        cycle();
        cdb_valid_i      = 2'b11;
        cdb_rob_idx_i[0] = model_q[1].idx;
        cdb_rob_idx_i[1] = model_q[2].idx;
        cycle();
        cdb_valid_i[0]   = 1'b1;
        cdb_rob_idx_i[0] = model_q[3].idx;
        cycle();
        cdb_valid_i[0]   = 1'b1;
        cdb_rob_idx_i[0] = model_q[0].idx;
        br_valid_i       = 1'b1;
        br_mispredict_i  = 1'b1;
        br_rob_idx_i     = model_q[0].idx;
        wait_for(1'b1, 0, 1'b0, "flush after mispredict");
        cycle();
        assert (rob_ready_o == 2'b11)
            else value_error("rob_ready_o", 32'(rob_ready_o), 32'h3);
        assert (dp_rob_idx_o == '0)
            else value_error("dp_rob_idx_o", 32'(dp_rob_idx_o), 32'h0);
        set_dispatch(0, 1'b0);
        wait_for(1'b0, 0, 1'b1, "drain after recovery");
        end_test("mispredict_recovery");

        $display("Summary: %0d tests, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/rob_pkg.sv
logic/rob_ptr_if.sv
logic/rob_ptr_ctrl.sv
logic/rob_entry_array.sv
logic/rob_recover_fsm.sv
logic/rob_top.sv
dv/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the ROB testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rob_tb -f filelist.f --Mdir obj_dir -o rob_sim

out=$(./obj_dir/rob_sim)
echo "$out"

if echo "$out" | grep -q "^Test completed successfully$"; then
    exit 0
fi
exit 1
